//--- verilog/tomasulo_params.svh
`ifndef TOMASULO_PARAMS_SVH
`define TOMASULO_PARAMS_SVH

// Datapath and tag space of the execution cluster.
`define XLEN         32
`define TAG_COUNT    8
`define TAG_WIDTH    3
`define RS_COUNT     2
`define RESULT_PORTS (`RS_COUNT + 1)

// Opcode classes carried in the op field of an issue word.
`define OP_ARITH  3'd0
`define OP_LD     3'd1
`define OP_JAL    3'd2
`define OP_JALR   3'd3
`define OP_BRANCH 3'd4

`endif

//--- verilog/tomasulo_pkg.sv
`default_nettype none

`include "tomasulo_params.svh"

package tomasulo_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [`TAG_WIDTH-1:0] tag_t;
    typedef logic [`TAG_COUNT-1:0] tag_mask_t;
    typedef logic [2:0]            op_t;

    // One instruction as it leaves the issue stage. Register-file operands
    // are already filled in; a clear valid bit means the value is still
    // owed by the reorder-buffer entry named in the tag field.
    typedef struct packed {
        op_t        op;
        logic [2:0] funct3;
        logic       funct7;
        tag_t       src1_tag;
        word_t      src1_data;
        logic       src1_valid;
        tag_t       src2_tag;
        word_t      src2_data;
        logic       src2_valid;
        tag_t       rd_tag;
        word_t      pc;
    } issue_word_t;

    // Operands are final by the time this word reaches the ALU.
    typedef struct packed {
        op_t        op;
        logic [2:0] funct3;
        logic       funct7;
        word_t      src1_data;
        word_t      src2_data;
        tag_t       tag;
        word_t      pc;
    } alu_word_t;

    // One entry on the result bus.
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
        logic  redirect;
        word_t redirect_pc;
    } result_t;

    typedef enum logic {
        EMPTY = 1'b0,
        WAIT  = 1'b1
    } station_state_e;

endpackage

`default_nettype wire

//--- verilog/dispatch_router.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_params.svh"

module dispatch_router (
    input  wire logic                 issue_valid,
    input  wire logic [`RS_COUNT-1:0] station_empty,
    output logic                      issue_stall,
    output logic [`RS_COUNT-1:0]      station_load
);

    logic found;

    // With no free station the source must hold its word.
    assign issue_stall = ~|station_empty;

    // The lowest-numbered empty station takes the word. A load pulse only
    // goes out when a station is free, so an accepted word always lands
    // at the same edge it is accepted.
    always_comb begin
        station_load = '0;
        found        = 1'b0;
        for (int i = 0; i < `RS_COUNT; i++) begin
            if (station_empty[i] && !found) begin
                station_load[i] = issue_valid && !issue_stall;
                found           = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/reservation_station.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_params.svh"

module reservation_station (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      load,
    input  wire tomasulo_pkg::issue_word_t issue_word,
    input  wire tomasulo_pkg::tag_mask_t   calculated,
    input  wire tomasulo_pkg::word_t       table_data [`TAG_COUNT],
    input  wire tomasulo_pkg::tag_mask_t   allocated,
    output logic                           empty,
    output logic                           start_exe,
    output tomasulo_pkg::alu_word_t        alu_word
);

    import tomasulo_pkg::*;

    station_state_e state;
    station_state_e next_state;
    issue_word_t    held;

    logic  src1_ready;
    logic  src2_ready;
    logic  flush;
    word_t src1_value;
    word_t src2_value;

    // An operand is ready once its own valid bit is set or the result
    // table has calculated its tag in an earlier cycle.
    assign src1_ready = held.src1_valid || calculated[held.src1_tag];
    assign src2_ready = held.src2_valid || calculated[held.src2_tag];

    assign src1_value = held.src1_valid ? held.src1_data : table_data[held.src1_tag];
    assign src2_value = held.src2_valid ? held.src2_data : table_data[held.src2_tag];

    // The reorder buffer dropped our destination, so the instruction is dead.
    assign flush = !allocated[held.rd_tag];

    assign empty     = (state == EMPTY);
    assign start_exe = (state == WAIT) && src1_ready && src2_ready && !flush;

    always_comb begin
        alu_word.op = held.op;
        // Loads and jumps need an address or target sum, so the ALU is
        // steered onto its add code regardless of the encoded funct3.
        if (held.op == `OP_LD || held.op == `OP_JAL || held.op == `OP_JALR) begin
            alu_word.funct3 = 3'b000;
        end else begin
            alu_word.funct3 = held.funct3;
        end
        alu_word.funct7    = held.funct7;
        alu_word.src1_data = src1_value;
        alu_word.src2_data = src2_value;
        alu_word.tag       = held.rd_tag;
        alu_word.pc        = held.pc;
    end

    always_comb begin
        next_state = state;
        case (state)
            EMPTY: begin
                if (load) begin
                    next_state = WAIT;
                end
            end
            WAIT: begin
                if (flush || (src1_ready && src2_ready)) begin
                    next_state = EMPTY;
                end
            end
            default: begin
                next_state = EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            state <= next_state;
        end
    end

    // Operand capture. A fresh word replaces everything; while waiting,
    // operands that the table has produced are copied in so the station
    // keeps them even if the tag is later reused.
    always_ff @(posedge clk) begin
        if (state == EMPTY && load) begin
            held <= issue_word;
        end else if (state == WAIT) begin
            if (!held.src1_valid && calculated[held.src1_tag]) begin
                held.src1_valid <= 1'b1;
                held.src1_data  <= table_data[held.src1_tag];
            end
            if (!held.src2_valid && calculated[held.src2_tag]) begin
                held.src2_valid <= 1'b1;
                held.src2_data  <= table_data[held.src2_tag];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_params.svh"

module alu_unit (
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    start_exe,
    input  wire tomasulo_pkg::alu_word_t alu_word,
    output tomasulo_pkg::result_t        result
);

    import tomasulo_pkg::*;

    word_t a;
    word_t b;
    word_t sum;
    word_t link;
    word_t value;
    logic  taken;
    logic  redirect;
    word_t redirect_pc;

    assign a    = alu_word.src1_data;
    assign b    = alu_word.src2_data;
    assign sum  = a + b;
    assign link = alu_word.pc + 32'd4;

    always_comb begin
        case (alu_word.funct3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            3'b110:  taken = (a < b);
            3'b111:  taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        value       = sum;
        redirect    = 1'b0;
        redirect_pc = '0;
        case (alu_word.op)
            `OP_ARITH: begin
                case (alu_word.funct3)
                    3'b000:  value = alu_word.funct7 ? a - b : sum;
                    3'b001:  value = a << b[4:0];
                    3'b010:  value = {31'd0, $signed(a) < $signed(b)};
                    3'b011:  value = {31'd0, a < b};
                    3'b100:  value = a ^ b;
                    3'b101:  value = alu_word.funct7 ? word_t'($signed(a) >>> b[4:0])
                                                     : a >> b[4:0];
                    3'b110:  value = a | b;
                    default: value = a & b;
                endcase
            end
            `OP_JAL: begin
                value = link;
            end
            `OP_JALR: begin
                value       = link;
                redirect    = 1'b1;
                redirect_pc = {sum[`XLEN-1:1], 1'b0};
            end
            `OP_BRANCH: begin
                // The branch reports its outcome as data for the reorder buffer.
                value       = {31'd0, taken};
                redirect    = taken;
                redirect_pc = taken ? alu_word.pc + b : '0;
            end
            default: begin
                value = sum;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        result.tag         <= alu_word.tag;
        result.data        <= value;
        result.redirect    <= redirect;
        result.redirect_pc <= redirect_pc;
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= start_exe;
        end
    end

endmodule

`default_nettype wire

//--- verilog/result_bus.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_params.svh"

module result_bus (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire tomasulo_pkg::result_t alu_results [`RS_COUNT],
    input  wire tomasulo_pkg::result_t ext_result,
    input  wire logic                  alloc_valid,
    input  wire tomasulo_pkg::tag_t    alloc_tag,
    output tomasulo_pkg::tag_mask_t    calculated,
    output tomasulo_pkg::word_t        table_data [`TAG_COUNT],
    output tomasulo_pkg::result_t      results [`RESULT_PORTS]
);

    import tomasulo_pkg::*;

    result_t in_ports [`RESULT_PORTS];

    // The ALUs take the low ports, the external writeback the last one.
    always_comb begin
        for (int i = 0; i < `RS_COUNT; i++) begin
            in_ports[i] = alu_results[i];
        end
        in_ports[`RS_COUNT] = ext_result;
    end

    // A reused tag loses its calculated bit, but a result written in the
    // same cycle is assigned later and therefore wins.
    always_ff @(posedge clk) begin
        if (rst) begin
            calculated <= '0;
        end else begin
            if (alloc_valid) begin
                calculated[alloc_tag] <= 1'b0;
            end
            for (int i = 0; i < `RESULT_PORTS; i++) begin
                if (in_ports[i].valid) begin
                    calculated[in_ports[i].tag] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `RESULT_PORTS; i++) begin
            if (in_ports[i].valid) begin
                table_data[in_ports[i].tag] <= in_ports[i].data;
            end
        end
    end

    // Broadcast copy of every port, one cycle behind its input.
    always_ff @(posedge clk) begin
        for (int i = 0; i < `RESULT_PORTS; i++) begin
            results[i] <= in_ports[i];
            if (rst) begin
                results[i].valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/exec_cluster.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_params.svh"

module exec_cluster (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      issue_valid,
    input  wire tomasulo_pkg::issue_word_t issue_word,
    output logic                           issue_stall,
    input  wire tomasulo_pkg::result_t     ext_result,
    input  wire logic                      alloc_valid,
    input  wire tomasulo_pkg::tag_t        alloc_tag,
    input  wire tomasulo_pkg::tag_mask_t   allocated,
    output tomasulo_pkg::result_t          results [`RESULT_PORTS]
);

    import tomasulo_pkg::*;

    logic [`RS_COUNT-1:0] station_empty;
    logic [`RS_COUNT-1:0] station_load;
    logic [`RS_COUNT-1:0] start_exe;
    alu_word_t            alu_word [`RS_COUNT];
    result_t              alu_results [`RS_COUNT];
    tag_mask_t            calculated;
    word_t                table_data [`TAG_COUNT];

    dispatch_router router (
        .issue_valid   (issue_valid),
        .station_empty (station_empty),
        .issue_stall   (issue_stall),
        .station_load  (station_load)
    );

    // Each station feeds its own ALU.
    for (genvar i = 0; i < `RS_COUNT; i++) begin : g_lane
        reservation_station station (
            .clk        (clk),
            .rst        (rst),
            .load       (station_load[i]),
            .issue_word (issue_word),
            .calculated (calculated),
            .table_data (table_data),
            .allocated  (allocated),
            .empty      (station_empty[i]),
            .start_exe  (start_exe[i]),
            .alu_word   (alu_word[i])
        );

        alu_unit alu (
            .clk       (clk),
            .rst       (rst),
            .start_exe (start_exe[i]),
            .alu_word  (alu_word[i]),
            .result    (alu_results[i])
        );
    end

    result_bus bus (
        .clk         (clk),
        .rst         (rst),
        .alu_results (alu_results),
        .ext_result  (ext_result),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .calculated  (calculated),
        .table_data  (table_data),
        .results     (results)
    );

endmodule

`default_nettype wire

//--- bench/exec_cluster_tb.sv
`default_nettype none
`timescale 1ns/1ns

`include "tomasulo_params.svh"

module exec_cluster_tb;

    import tomasulo_pkg::*;

    localparam int RANDOM_WORDS = 48;
    localparam int ISSUE_TOTAL  = RANDOM_WORDS + 23;
    localparam int MAX_CYCLES   = 40 * ISSUE_TOTAL + 200;
    // A ready word passes the load edge, the ALU register and the broadcast
    // register, so it shows two edges after the edge that accepts it.
    localparam int READY_LATENCY = 2;

    logic        clk = 1'b0;
    logic        rst;
    logic        issue_valid;
    issue_word_t issue_word;
    logic        issue_stall;
    result_t     ext_result;
    logic        alloc_valid;
    tag_t        alloc_tag;
    tag_mask_t   allocated;
    result_t     results [`RESULT_PORTS];

    // Scoreboard with one slot per tag; a tag is busy while the counts differ.
    result_t expected_result [`TAG_COUNT];
    int      due_cycle [`TAG_COUNT];
    int      expect_count [`TAG_COUNT] = '{default: 0};
    int      seen_count [`TAG_COUNT] = '{default: 0};
    int      cycles = 0;

    exec_cluster DUT (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_word  (issue_word),
        .issue_stall (issue_stall),
        .ext_result  (ext_result),
        .alloc_valid (alloc_valid),
        .alloc_tag   (alloc_tag),
        .allocated   (allocated),
        .results     (results)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("TESTS FAILED");
            $fatal(1, "Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
        end
    end

    task automatic compare(input string name, input logic [31:0] expected_value,
                           input logic [31:0] actual_value);
        if (expected_value !== actual_value) begin
            $display("FAIL %s expected %h actual %h", name, expected_value, actual_value);
            $display("TESTS FAILED");
            $fatal(1, "Mismatch in %s.", name);
        end
    endtask

    task automatic stop_with_error(input string message);
        $display("%s", message);
        $display("TESTS FAILED");
        $fatal(1, "%s", message);
    endtask

    // Expected result of one word, worked out from the RV32I rules.
    function automatic result_t ref_result(input issue_word_t w, input word_t s1,
                                           input word_t s2);
        result_t    r;
        logic       taken;
        logic [4:0] shamt;
        word_t      fill;
        r        = '0;
        r.valid  = 1'b1;
        r.tag    = w.rd_tag;
        shamt    = s2[4:0];
        fill     = s1[31] ? ~(32'hffff_ffff >> shamt) : 32'd0;
        case (w.funct3)
            3'b000:  taken = (s1 == s2);
            3'b001:  taken = (s1 != s2);
            3'b100:  taken = ($signed(s1) < $signed(s2));
            3'b101:  taken = !($signed(s1) < $signed(s2));
            3'b110:  taken = (s1 < s2);
            3'b111:  taken = !(s1 < s2);
            default: taken = 1'b0;
        endcase
        case (w.op)
            `OP_ARITH: begin
                case (w.funct3)
                    3'b000:  r.data = w.funct7 ? s1 - s2 : s1 + s2;
                    3'b001:  r.data = s1 << shamt;
                    3'b010:  r.data = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
                    3'b011:  r.data = (s1 < s2) ? 32'd1 : 32'd0;
                    3'b100:  r.data = s1 ^ s2;
                    3'b101:  r.data = w.funct7 ? (s1 >> shamt) | fill : s1 >> shamt;
                    3'b110:  r.data = s1 | s2;
                    default: r.data = s1 & s2;
                endcase
            end
            `OP_JAL: r.data = w.pc + 32'd4;
            `OP_JALR: begin
                r.data        = w.pc + 32'd4;
                r.redirect    = 1'b1;
                r.redirect_pc = (s1 + s2) & ~32'd1;
            end
            `OP_BRANCH: begin
                r.data        = taken ? 32'd1 : 32'd0;
                r.redirect    = taken;
                r.redirect_pc = taken ? w.pc + s2 : 32'd0;
            end
            default: r.data = s1 + s2;
        endcase
        return r;
    endfunction

    function automatic issue_word_t random_word(input op_t op, input tag_t rd);
        issue_word_t w;
        word_t       rnd;
        rnd          = $urandom;
        w            = '0;
        w.op         = op;
        w.funct3     = rnd[2:0];
        w.funct7     = rnd[3];
        w.src1_tag   = rnd[6:4];
        w.src2_tag   = rnd[9:7];
        w.src1_data  = $urandom;
        w.src2_data  = $urandom;
        w.src1_valid = 1'b1;
        w.src2_valid = 1'b1;
        w.rd_tag     = rd;
        w.pc         = $urandom;
        w.pc[1:0]    = 2'b00;
        return w;
    endfunction

    function automatic bit outstanding();
        bit busy;
        busy = 1'b0;
        for (int i = 0; i < `TAG_COUNT; i++) begin
            busy = busy || (expect_count[i] != seen_count[i]);
        end
        return busy;
    endfunction

    task automatic expect_tag(input tag_t t, input result_t r, input int due);
        expected_result[t] = r;
        due_cycle[t]       = due;
        expect_count[t]    = expect_count[t] + 1;
    endtask

    task automatic drain();
        while (outstanding()) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Holds the word until the router takes it; returns the accepting edge.
    task automatic issue(input issue_word_t w, output int accept);
        bit taken;
        taken = 1'b0;
        while (expect_count[w.rd_tag] != seen_count[w.rd_tag]) begin
            @(posedge clk);
            #1;
        end
        issue_valid = 1'b1;
        issue_word  = w;
        while (!taken) begin
            @(negedge clk);
            taken  = !issue_stall;
            accept = cycles + 1;
            @(posedge clk);
        end
        #1;
        issue_valid = 1'b0;
    endtask

    task automatic issue_ready(input issue_word_t w);
        int accept;
        issue(w, accept);
        expect_tag(w.rd_tag, ref_result(w, w.src1_data, w.src2_data),
                   accept + READY_LATENCY);
    endtask

    task automatic clear_tag(input tag_t t);
        alloc_valid = 1'b1;
        alloc_tag   = t;
        @(posedge clk);
        #1;
        alloc_valid = 1'b0;
    endtask

    task automatic write_ext(input tag_t t, input word_t data);
        result_t r;
        r          = '0;
        r.valid    = 1'b1;
        r.tag      = t;
        r.data     = data;
        ext_result = r;
        expect_tag(t, r, cycles + 1);
        @(posedge clk);
        #1;
        ext_result.valid = 1'b0;
    endtask

    task automatic check_result(input result_t r);
        string name;
        name = $sformatf("tag %0d", r.tag);
        if (seen_count[r.tag] >= expect_count[r.tag]) begin
            stop_with_error($sformatf("A result for tag %0d arrived that was not expected.",
                                      r.tag));
        end else begin
            compare({name, " data"}, expected_result[r.tag].data, r.data);
            compare({name, " redirect"}, 32'(expected_result[r.tag].redirect),
                    32'(r.redirect));
            compare({name, " redirect pc"}, expected_result[r.tag].redirect_pc,
                    r.redirect_pc);
            if (due_cycle[r.tag] != 0) begin
                compare({name, " latency"}, due_cycle[r.tag], cycles);
            end
            seen_count[r.tag] = seen_count[r.tag] + 1;
        end
    endtask

    // Outputs change at the rising edge, so they are checked at the falling one.
    always @(negedge clk) begin
        if (!rst) begin
            for (int p = 0; p < `RESULT_PORTS; p++) begin
                if (results[p].valid) begin
                    check_result(results[p]);
                end
            end
        end
    end

    initial begin
        issue_word_t w;
        issue_word_t w1;
        issue_word_t w2;
        issue_word_t w3;
        result_t     first;
        int          accept;
        word_t       rnd;
        word_t       data;
        tag_t        next_tag;
        rnd         = $urandom(32'ha72f_e076);
        rst         = 1'b1;
        issue_valid = 1'b0;
        issue_word  = '0;
        ext_result  = '0;
        alloc_valid = 1'b0;
        alloc_tag   = '0;
        allocated   = '1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        compare("stall after reset", 32'd0, 32'(issue_stall));
        for (int p = 0; p < `RESULT_PORTS; p++) begin
            compare($sformatf("port %0d valid after reset", p), 32'd0, 32'(results[p].valid));
        end
        @(posedge clk);
        #1;

        // Ready words; the first sixteen walk every funct3 and funct7 pair.
        // Odd codes get a negative first operand so the right shifts differ.
        for (int i = 0; i < RANDOM_WORDS; i++) begin
            rnd = $urandom;
            w = random_word((i < 16 || rnd[0]) ? `OP_ARITH : `OP_LD, 3'(i));
            if (i < 16) begin
                w.funct3        = 3'(i);
                w.funct7        = i[3];
                w.src1_data[31] = i[0];
            end
            issue_ready(w);
            repeat (rnd[2:1]) begin
                @(posedge clk);
                #1;
            end
        end

        // A missing operand is only supplied by the external writeback.
        drain();
        clear_tag(3'd5);
        w = random_word(`OP_ARITH, 3'd1);
        w.src1_tag   = 3'd5;
        w.src1_valid = 1'b0;
        issue(w, accept);
        repeat (6) @(posedge clk);
        #1;
        data = $urandom;
        write_ext(3'd5, data);
        expect_tag(3'd1, ref_result(w, data, w.src2_data), 0);

        // Dependent pair, the second word reading the first one's tag.
        drain();
        clear_tag(3'd2);
        w1 = random_word(`OP_ARITH, 3'd2);
        w2 = random_word(`OP_LD, 3'd3);
        w2.src1_tag   = 3'd2;
        w2.src1_valid = 1'b0;
        first = ref_result(w1, w1.src1_data, w1.src2_data);
        issue_ready(w1);
        issue(w2, accept);
        expect_tag(3'd3, ref_result(w2, first.data, w2.src2_data), 0);

        // Jumps, then every branch compare with equal and random operands.
        drain();
        issue_ready(random_word(`OP_JAL, 3'd0));
        issue_ready(random_word(`OP_JALR, 3'd1));
        next_tag = 3'd2;
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 2; k++) begin
                if (f != 2 && f != 3) begin
                    w = random_word(`OP_BRANCH, next_tag);
                    w.funct3 = 3'(f);
                    if (k == 0) begin
                        w.src2_data = w.src1_data;
                    end
                    issue_ready(w);
                    next_tag = next_tag + 3'd1;
                end
            end
        end

        // Flush of a waiting station whose destination tag is dropped.
        drain();
        clear_tag(3'd6);
        clear_tag(3'd7);
        w1 = random_word(`OP_ARITH, 3'd4);
        w1.src1_tag   = 3'd6;
        w1.src1_valid = 1'b0;
        w2 = random_word(`OP_ARITH, 3'd5);
        w2.src1_tag   = 3'd7;
        w2.src1_valid = 1'b0;
        issue(w1, accept);
        issue(w2, accept);
        @(negedge clk);
        compare("stall with both stations waiting", 32'd1, 32'(issue_stall));
        @(posedge clk);
        #1;
        allocated[4] = 1'b0;
        @(posedge clk);
        #1;
        allocated[4] = 1'b1;
        issue_ready(random_word(`OP_ARITH, 3'd0));
        write_ext(3'd6, $urandom);
        data = $urandom;
        write_ext(3'd7, data);
        expect_tag(3'd5, ref_result(w2, data, w2.src2_data), 0);

        // A third word is held under stall until a station frees up.
        drain();
        clear_tag(3'd1);
        clear_tag(3'd2);
        w1 = random_word(`OP_ARITH, 3'd3);
        w1.src1_tag   = 3'd1;
        w1.src1_valid = 1'b0;
        w2 = random_word(`OP_LD, 3'd4);
        w2.src2_tag   = 3'd2;
        w2.src2_valid = 1'b0;
        w3 = random_word(`OP_ARITH, 3'd5);
        issue(w1, accept);
        issue(w2, accept);
        fork
            begin
                issue(w3, accept);
                expect_tag(3'd5, ref_result(w3, w3.src1_data, w3.src2_data),
                           accept + READY_LATENCY);
            end
            begin
                repeat (4) begin
                    @(negedge clk);
                    compare("stall while a word is held", 32'd1, 32'(issue_stall));
                end
                @(posedge clk);
                #1;
                data = $urandom;
                write_ext(3'd1, data);
                expect_tag(3'd3, ref_result(w1, data, w1.src2_data), 0);
                data = $urandom;
                write_ext(3'd2, data);
                expect_tag(3'd4, ref_result(w2, w2.src1_data, data), 0);
            end
        join
        drain();

        // Idle cycles give a duplicate report the chance to show up.
        repeat (10) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verilog
verilog/tomasulo_pkg.sv
verilog/dispatch_router.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/result_bus.sv
verilog/exec_cluster.sv
bench/exec_cluster_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing
TOP       := exec_cluster_tb
FILELIST  := verilog.f
LOG       := sim.log

BIN     := obj_dir/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
